// ==== hw/ex_defs.svh ====
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

`define EX_XLEN          64
`define EX_WORD_W        32
`define EX_INSN_W        32
`define EX_REG_ADDR_W    5

// offset bits 12 down to 1, bit 0 is always zero
`define EX_BIMM_W        12

`define EX_OPCODE_BRANCH 7'b1100011

// one shift-add step per data bit
`define EX_MUL_CYCLES    `EX_XLEN

`endif

// ==== hw/ex_op_pkg.sv ====
`include "ex_defs.svh"

package ex_op_pkg;

	typedef logic [`EX_XLEN-1:0]   xlen_t;
	typedef logic [`EX_WORD_W-1:0] word_t;

	typedef enum logic [4:0] {
		op_add   = 5'd0,
		op_addw  = 5'd1,
		op_sll   = 5'd2,
		op_sllw  = 5'd3,
		op_sra   = 5'd4,
		op_sraw  = 5'd5,
		op_srl   = 5'd6,
		op_srlw  = 5'd7,
		op_and   = 5'd8,
		op_or    = 5'd9,
		op_xor   = 5'd10,
		op_slt   = 5'd11,
		op_sltu  = 5'd12,
		op_eq    = 5'd13,
		op_ne    = 5'd14,
		op_sge   = 5'd15,
		op_sgeu  = 5'd16,
		op_sub   = 5'd17,
		op_subw  = 5'd18,
		op_mul   = 5'd19, // low half
		op_mulh  = 5'd20, // signed high half
		op_mulhu = 5'd21, // unsigned high half
		op_mulw  = 5'd22
	} alu_op_e;

	function automatic xlen_t sext_word(input word_t w);
		return {{(`EX_XLEN-`EX_WORD_W){w[`EX_WORD_W-1]}}, w};
	endfunction

endpackage

// ==== hw/ex_pipe_pkg.sv ====
`include "ex_defs.svh"

package ex_pipe_pkg;

	typedef struct packed {
		ex_op_pkg::xlen_t          pc;
		logic [`EX_INSN_W-1:0]     ins;
		ex_op_pkg::alu_op_e        op;
		ex_op_pkg::xlen_t          src_a;
		ex_op_pkg::xlen_t          src_b;
		logic [`EX_BIMM_W-1:0]     bimm;
		logic                      is_branch;
		logic                      mem_w_en;
		logic                      wb_sel;    // high selects load data at write-back
		logic                      reg_w_en;
		ex_op_pkg::xlen_t          rt_data;   // store data
		logic [`EX_REG_ADDR_W-1:0] rd;
	} ex_in_t;

	typedef struct packed {
		ex_op_pkg::xlen_t          pc;
		logic [`EX_INSN_W-1:0]     ins;
		logic                      mem_w_en;
		logic                      wb_sel;
		logic                      reg_w_en;
		ex_op_pkg::xlen_t          rt_data;
		logic [`EX_REG_ADDR_W-1:0] rd;
		ex_op_pkg::xlen_t          result;
	} ex_out_t;

	typedef struct packed {
		logic                      bubble;
		logic                      taken;
		ex_op_pkg::xlen_t          target;
	} branch_info_t;

endpackage

// ==== hw/ex_alu.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_alu (
	input  ex_op_pkg::alu_op_e op,
	input  ex_op_pkg::xlen_t   src_a,
	input  ex_op_pkg::xlen_t   src_b,
	output ex_op_pkg::xlen_t   result
);
	import ex_op_pkg::*;

	localparam int SH_W  = $clog2(`EX_XLEN);
	localparam int SHW_W = $clog2(`EX_WORD_W);

	logic [SH_W-1:0]  sh;
	logic [SHW_W-1:0] shw;
	word_t            wa;
	word_t            wb;
	word_t            w_sra;

	assign sh  = src_b[SH_W-1:0];
	assign shw = src_b[SHW_W-1:0];
	assign wa  = src_a[`EX_WORD_W-1:0];
	assign wb  = src_b[`EX_WORD_W-1:0];

	assign w_sra = $signed(wa) >>> shw;

	always_comb begin
		case (op)
			op_add: begin
				result = src_a + src_b;
			end
			op_addw: begin
				result = sext_word(wa + wb);
			end
			op_sll: begin
				result = src_a << sh;
			end
			op_sllw: begin
				result = sext_word(wa << shw);
			end
			op_sra: begin
				result = $signed(src_a) >>> sh;
			end
			op_sraw: begin
				result = sext_word(w_sra);
			end
			op_srl: begin
				result = src_a >> sh;
			end
			op_srlw: begin
				result = sext_word(wa >> shw); // logical shift, then extend bit 31
			end
			op_and:  result = src_a & src_b;
			op_or:   result = src_a | src_b;
			op_xor:  result = src_a ^ src_b;
			op_slt:  result = xlen_t'($signed(src_a) < $signed(src_b));
			op_sltu: result = xlen_t'(src_a < src_b);
			op_eq:   result = xlen_t'(src_a == src_b);
			op_ne:   result = xlen_t'(src_a != src_b);
			op_sge:  result = xlen_t'($signed(src_a) >= $signed(src_b));
			op_sgeu: result = xlen_t'(src_a >= src_b);
			op_sub: begin
				result = src_a - src_b;
			end
			op_subw: begin
				result = sext_word(wa - wb);
			end
			default: begin
				result = '0; // multiplies and unused codes
			end
		endcase
	end

endmodule

// ==== hw/ex_multiplier.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_multiplier #(
	parameter int WIDTH = `EX_XLEN
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	input  logic [WIDTH-1:0]   a,
	input  logic [WIDTH-1:0]   b,
	input  logic               a_signed,
	input  logic               b_signed,
	output logic               busy,
	output logic               done,
	output logic [2*WIDTH-1:0] product
);
	localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

	logic               a_neg;
	logic               b_neg;
	logic [WIDTH-1:0]   a_mag;
	logic [WIDTH-1:0]   b_mag;
	logic [WIDTH-1:0]   mcand;
	logic [2*WIDTH-1:0] acc;      // partial sum on top, multiplier bits below
	logic               negate;
	logic [CNT_W-1:0]   count;
	logic [WIDTH:0]     step_sum;
	logic               load;

	assign a_neg = a_signed & a[WIDTH-1];
	assign b_neg = b_signed & b[WIDTH-1];
	assign a_mag = a_neg ? -a : a;
	assign b_mag = b_neg ? -b : b;

	assign load = start && !busy;

	// add multiplicand when the current multiplier bit is set
	assign step_sum = {1'b0, acc[2*WIDTH-1:WIDTH]} + (acc[0] ? {1'b0, mcand} : '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (load) begin
				busy  <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 1'b1;
				if (count == CNT_W'(WIDTH-1)) begin // last step
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			mcand  <= a_mag;
			acc    <= {{WIDTH{1'b0}}, b_mag};
			negate <= a_neg ^ b_neg;
		end else if (busy) begin
			acc <= {step_sum, acc[WIDTH-1:1]};
		end
	end

	assign product = negate ? -acc : acc; // held until the next start

endmodule

// ==== hw/ex_branch_unit.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_branch_unit (
	input  ex_op_pkg::xlen_t          pc,
	input  logic [`EX_INSN_W-1:0]     ins,
	input  logic [`EX_BIMM_W-1:0]     bimm,
	input  logic                      is_branch,
	input  ex_op_pkg::xlen_t          alu_result,
	input  logic                      accept,
	output ex_pipe_pkg::branch_info_t branch
);
	import ex_op_pkg::*;

	xlen_t offset;
	logic  is_btype;

	assign offset   = {{(`EX_XLEN-`EX_BIMM_W-1){bimm[`EX_BIMM_W-1]}}, bimm, 1'b0};
	assign is_btype = ins[6:0] == `EX_OPCODE_BRANCH;

	always_comb begin
		branch.target = pc + offset;
		branch.taken  = is_branch & (|alu_result); // compare result is 0 or 1
		branch.bubble = accept & is_btype;
	end

endmodule

// ==== hw/ex_issue_ctrl.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_issue_ctrl (
	input  logic                  clk,
	input  logic                  reset,
	input  ex_pipe_pkg::ex_in_t   in,
	input  logic                  in_valid,
	output logic                  in_ready,
	output logic                  accept,
	input  ex_op_pkg::xlen_t      alu_result,
	output logic                  mul_start,
	output ex_op_pkg::xlen_t      mul_a,
	output ex_op_pkg::xlen_t      mul_b,
	output logic                  mul_a_signed,
	output logic                  mul_b_signed,
	input  logic                  mul_busy,
	input  logic                  mul_done,
	input  logic [2*`EX_XLEN-1:0] mul_product,
	output ex_pipe_pkg::ex_out_t  out,
	output logic                  out_valid,
	input  logic                  out_ready
);
	import ex_op_pkg::*;
	import ex_pipe_pkg::*;

	ex_in_t hold;        // multiply waiting on its product
	logic   is_mul;
	logic   is_word;
	logic   mul_held;    // product done but output register was full
	logic   mul_avail;
	logic   mul_load;
	logic   out_room;
	xlen_t  mul_result;

	function automatic ex_out_t pack_out(input ex_in_t src, input xlen_t res);
		ex_out_t o;
		o.pc       = src.pc;
		o.ins      = src.ins;
		o.mem_w_en = src.mem_w_en;
		o.wb_sel   = src.wb_sel;
		o.reg_w_en = src.reg_w_en;
		o.rt_data  = src.rt_data;
		o.rd       = src.rd;
		o.result   = res;
		return o;
	endfunction

	assign is_mul  = in.op inside {op_mul, op_mulh, op_mulhu, op_mulw};
	assign is_word = in.op == op_mulw;

	assign out_room  = !out_valid || out_ready;
	assign mul_avail = mul_done || mul_held;
	assign mul_load  = mul_avail && out_room;

	// closed from multiply acceptance until its result is loaded
	assign in_ready  = out_room && !mul_busy && !mul_avail;
	assign accept    = in_valid && in_ready;
	assign mul_start = accept && is_mul;

	assign mul_a        = is_word ? sext_word(in.src_a[`EX_WORD_W-1:0]) : in.src_a;
	assign mul_b        = is_word ? sext_word(in.src_b[`EX_WORD_W-1:0]) : in.src_b;
	assign mul_a_signed = in.op inside {op_mulh, op_mulw};
	assign mul_b_signed = in.op inside {op_mulh, op_mulw};

	always_comb begin
		case (hold.op)
			op_mulh, op_mulhu: begin
				mul_result = mul_product[2*`EX_XLEN-1:`EX_XLEN];
			end
			op_mulw: begin
				mul_result = sext_word(mul_product[`EX_WORD_W-1:0]);
			end
			default: begin
				mul_result = mul_product[`EX_XLEN-1:0];
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			mul_held  <= 1'b0;
		end else begin
			if (out_valid && out_ready) begin
				out_valid <= 1'b0;
			end
			if ((accept && !is_mul) || mul_load) begin
				out_valid <= 1'b1;
			end
			mul_held <= mul_avail && !mul_load;
		end
	end

	always_ff @(posedge clk) begin
		if (mul_start) begin
			hold <= in;
		end
		if (mul_load) begin
			out <= pack_out(hold, mul_result);
		end else if (accept && !is_mul) begin
			out <= pack_out(in, alu_result);
		end
	end

endmodule

// ==== hw/ex_stage.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_stage (
	input  logic                      clk,
	input  logic                      reset,
	input  ex_pipe_pkg::ex_in_t       in,
	input  logic                      in_valid,
	output logic                      in_ready,
	output ex_pipe_pkg::ex_out_t      out,
	output logic                      out_valid,
	input  logic                      out_ready,
	output ex_pipe_pkg::branch_info_t branch
);
	import ex_op_pkg::*;

	xlen_t                 alu_result;
	logic                  accept;
	logic                  mul_start;
	xlen_t                 mul_a;
	xlen_t                 mul_b;
	logic                  mul_a_signed;
	logic                  mul_b_signed;
	logic                  mul_busy;
	logic                  mul_done;
	logic [2*`EX_XLEN-1:0] mul_product;

	ex_alu u_alu (
		.op     (in.op),
		.src_a  (in.src_a),
		.src_b  (in.src_b),
		.result (alu_result)
	);

	ex_multiplier #(
		.WIDTH (`EX_XLEN)
	) u_mul (
		.clk      (clk),
		.reset    (reset),
		.start    (mul_start),
		.a        (mul_a),
		.b        (mul_b),
		.a_signed (mul_a_signed),
		.b_signed (mul_b_signed),
		.busy     (mul_busy),
		.done     (mul_done),
		.product  (mul_product)
	);

	ex_branch_unit u_branch (
		.pc         (in.pc),
		.ins        (in.ins),
		.bimm       (in.bimm),
		.is_branch  (in.is_branch),
		.alu_result (alu_result),
		.accept     (accept),
		.branch     (branch)
	);

	ex_issue_ctrl u_ctrl (
		.clk          (clk),
		.reset        (reset),
		.in           (in),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.accept       (accept),
		.alu_result   (alu_result),
		.mul_start    (mul_start),
		.mul_a        (mul_a),
		.mul_b        (mul_b),
		.mul_a_signed (mul_a_signed),
		.mul_b_signed (mul_b_signed),
		.mul_busy     (mul_busy),
		.mul_done     (mul_done),
		.mul_product  (mul_product),
		.out          (out),
		.out_valid    (out_valid),
		.out_ready    (out_ready)
	);

endmodule

// ==== tb/ex_stage_checker.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_stage_checker (
	input  logic                 clk,
	input  logic                 reset,
	input  ex_pipe_pkg::ex_in_t  in,
	input  logic                 in_valid,
	input  logic                 in_ready,
	input  ex_pipe_pkg::ex_out_t out,
	input  logic                 out_valid,
	input  logic                 out_ready,
	input  ex_pipe_pkg::ex_out_t exp_out,   // expected output of the row being presented
	input  logic                 report,
	input  int                   tb_errors,
	output int                   errors,
	output int                   checked
);
	import ex_op_pkg::*;
	import ex_pipe_pkg::*;

	ex_out_t expect_q[$];
	ex_out_t held;
	logic    stalled;
	logic    reported;
	int      mul_wait;   // edges left where in_ready must stay low

	function automatic int field_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] want);
		if (got !== want) begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, want, got);
			return 1;
		end
		return 0;
	endfunction

	always @(posedge clk) begin
		ex_out_t want;
		int      bad;
		if (reset) begin
			errors   = 0;
			checked  = 0;
			mul_wait = 0;
			stalled  = 1'b0;
			reported = 1'b0;
			expect_q.delete();
		end else begin
			if (mul_wait > 0) begin
				if (in_ready !== 1'b0) begin
					$display("[FAIL] %0t in_ready expected 0 got %b", $time, in_ready);
					errors++;
				end
				mul_wait--;
			end
			if (in_valid && in_ready) begin
				expect_q.push_back(exp_out);
				if (in.op inside {op_mul, op_mulh, op_mulhu, op_mulw})
					mul_wait = `EX_MUL_CYCLES;
			end
			if (stalled && (!out_valid || out !== held)) begin
				$display("output changed at %0t while out_ready was low", $time);
				errors++;
			end
			stalled = out_valid && !out_ready;
			held    = out;
			if (out_valid && out_ready) begin
				if (expect_q.size() == 0) begin
					$display("an output left at %0t with no accepted row to match it", $time);
					errors++;
				end else begin
					want = expect_q.pop_front();
					bad  = field_mismatch("out.result", out.result, want.result);
					bad += field_mismatch("out.pc", out.pc, want.pc);
					bad += field_mismatch("out.ins", 64'(out.ins), 64'(want.ins));
					bad += field_mismatch("out.rt_data", out.rt_data, want.rt_data);
					bad += field_mismatch("out.rd", 64'(out.rd), 64'(want.rd));
					bad += field_mismatch("out.mem_w_en", 64'(out.mem_w_en),
						64'(want.mem_w_en));
					bad += field_mismatch("out.wb_sel", 64'(out.wb_sel),
						64'(want.wb_sel));
					bad += field_mismatch("out.reg_w_en", 64'(out.reg_w_en),
						64'(want.reg_w_en));
					if (bad == 0)
						$display("[ok] row %0d result %h", checked, out.result);
					errors += bad;
					checked++;
				end
			end
			if (report && !reported) begin
				reported = 1'b1;
				if (expect_q.size() != 0) begin
					$display("%0d accepted rows never reached the output", expect_q.size());
					errors++;
				end
				$display("summary: %0d results checked, %0d output errors, %0d input-side errors",
					checked, errors, tb_errors);
			end
		end
	end

endmodule

// ==== tb/ex_stage_tb.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_stage_tb;
	import ex_op_pkg::*;
	import ex_pipe_pkg::*;

	logic         clk;
	logic         reset;
	ex_in_t       in;
	logic         in_valid;
	logic         in_ready;
	ex_out_t      out;
	logic         out_valid;
	logic         out_ready;
	branch_info_t branch;
	ex_out_t      exp_out;
	logic         report;
	logic         table_built;
	int           tb_errors;
	int           chk_errors;
	int           checked;
	int           rand_seed;

	ex_in_t       row_in[$];
	ex_out_t      row_exp[$];
	branch_info_t row_br[$];   // bubble column marks a B-type opcode

	ex_stage dut0 (
		.clk       (clk),
		.reset     (reset),
		.in        (in),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out       (out),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.branch    (branch)
	);

	ex_stage_checker chk0 (
		.clk       (clk),
		.reset     (reset),
		.in        (in),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out       (out),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.exp_out   (exp_out),
		.report    (report),
		.tb_errors (tb_errors),
		.errors    (chk_errors),
		.checked   (checked)
	);

	task automatic add_row(input alu_op_e op, input xlen_t a, input xlen_t b, input xlen_t res,
			input logic br, input xlen_t pc, input logic [`EX_BIMM_W-1:0] bimm,
			input logic taken, input xlen_t target);
		ex_in_t       r;
		ex_out_t      e;
		branch_info_t bi;
		r.pc        = pc;
		r.ins       = {25'(row_in.size()), br ? `EX_OPCODE_BRANCH : 7'h33};
		r.op        = op;
		r.src_a     = a;
		r.src_b     = b;
		r.bimm      = bimm;
		r.is_branch = br;
		r.mem_w_en  = 1'($urandom);
		r.wb_sel    = 1'($urandom);
		r.reg_w_en  = 1'($urandom);
		r.rt_data   = {$urandom, $urandom};
		r.rd        = 5'($urandom);
		e.pc        = r.pc;
		e.ins       = r.ins;
		e.mem_w_en  = r.mem_w_en;
		e.wb_sel    = r.wb_sel;
		e.reg_w_en  = r.reg_w_en;
		e.rt_data   = r.rt_data;
		e.rd        = r.rd;
		e.result    = res;
		bi.bubble   = br;
		bi.taken    = taken;
		bi.target   = target;
		row_in.push_back(r);
		row_exp.push_back(e);
		row_br.push_back(bi);
	endtask

	// non-branch rows share one pc and offset
	task automatic alu_row(input alu_op_e op, input xlen_t a, input xlen_t b, input xlen_t res);
		add_row(op, a, b, res, 1'b0, 64'h1000, 12'h004, 1'b0, 64'h1008);
	endtask

	task automatic build_table();
		alu_row(op_add, 64'h0000_0000_ffff_ffff, 64'd1, 64'h0000_0001_0000_0000);
		alu_row(op_sub, 64'd5, 64'd7, 64'hffff_ffff_ffff_fffe);
		alu_row(op_sll, 64'h8000_0000_0000_0001, 64'h7c, 64'h1000_0000_0000_0000); // 6-bit amount
		alu_row(op_sra, 64'h8000_0000_0000_0000, 64'd4, 64'hf800_0000_0000_0000);
		alu_row(op_srl, 64'h8000_0000_0000_0000, 64'd4, 64'h0800_0000_0000_0000);
		alu_row(op_and, 64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0, 64'h0f00_0f00_0f00_0f00);
		alu_row(op_or, 64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0, 64'hfff0_fff0_fff0_fff0);
		alu_row(op_xor, 64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0, 64'hf0f0_f0f0_f0f0_f0f0);
		alu_row(op_sge, 64'd1, 64'hffff_ffff_ffff_ffff, 64'd1);
		alu_row(op_sgeu, 64'd1, 64'hffff_ffff_ffff_ffff, 64'd0);
		alu_row(op_addw, 64'h1234_5678_7fff_ffff, 64'd1, 64'hffff_ffff_8000_0000);
		alu_row(op_subw, 64'hffff_ffff_0000_0001, 64'd2, 64'hffff_ffff_ffff_ffff);
		alu_row(op_sllw, 64'd1, 64'd31, 64'hffff_ffff_8000_0000);
		alu_row(op_sraw, 64'h0000_0000_8000_0000, 64'h24, 64'hffff_ffff_f800_0000);
		alu_row(op_srlw, 64'hffff_ffff_8000_0000, 64'd4, 64'h0000_0000_0800_0000);
		alu_row(op_mul, 64'hffff_ffff_ffff_fffd, 64'd5, 64'hffff_ffff_ffff_fff1);
		alu_row(op_mulh, 64'hffff_ffff_ffff_fffd, 64'd5, 64'hffff_ffff_ffff_ffff);
		alu_row(op_mulhu, 64'hffff_ffff_ffff_fffd, 64'd5, 64'd4);
		alu_row(op_mulh, 64'h4000_0000_0000_0000, 64'd8, 64'd2);
		alu_row(op_mulw, 64'h1111_1111_0001_0000, 64'h8000, 64'hffff_ffff_8000_0000);
		alu_row(op_mul, 64'h0000_0001_0000_0001, 64'h0000_0001_0000_0001, 64'h0000_0002_0000_0001);
		alu_row(alu_op_e'(5'd25), 64'd9, 64'd9, 64'd0); // unused code
		add_row(op_slt, '1, 64'd1, 64'd1, 1'b1, 64'h3000, 12'h010, 1'b1, 64'h3020);
		add_row(op_sltu, '1, 64'd1, 64'd0, 1'b1, 64'h3004, 12'h800, 1'b0, 64'h2004);
		add_row(op_eq, 64'h55, 64'h55, 64'd1, 1'b1, 64'h4000, 12'h7ff, 1'b1, 64'h4ffe);
		add_row(op_ne, 64'h55, 64'h55, 64'd0, 1'b1, 64'h4000, 12'h000, 1'b0, 64'h4000);
	endtask

	task automatic compare_branch(input int idx);
		logic want_bubble;
		want_bubble = in_ready && row_br[idx].bubble; // only on a transfer
		if (branch.target !== row_br[idx].target) begin
			$display("[FAIL] %0t branch.target expected %h got %h", $time,
				row_br[idx].target, branch.target);
			tb_errors++;
		end
		if (branch.taken !== row_br[idx].taken) begin
			$display("[FAIL] %0t branch.taken expected %b got %b", $time,
				row_br[idx].taken, branch.taken);
			tb_errors++;
		end
		if (branch.bubble !== want_bubble) begin
			$display("[FAIL] %0t branch.bubble expected %b got %b", $time,
				want_bubble, branch.bubble);
			tb_errors++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1 out_ready = ($urandom % 3) != 0; // low about a third of the time
		end
	end

	initial begin
		wait (table_built);
		#(row_in.size() * (`EX_MUL_CYCLES + 10) * 4);
		$display("timeout: the run did not finish in time, %0d outputs seen", checked);
		$display("Test failed");
		$finish;
	end

	initial begin
		logic accepted;
		rand_seed   = $urandom(32'h790dc992);
		reset       = 1'b1;
		in          = '0;
		in_valid    = 1'b0;
		exp_out     = '0;
		report      = 1'b0;
		tb_errors   = 0;
		table_built = 1'b0;
		build_table();
		table_built = 1'b1;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		@(posedge clk);
		if (out_valid !== 1'b0) begin
			$display("[FAIL] %0t out_valid expected 0 got %b", $time, out_valid);
			tb_errors++;
		end
		if (in_ready !== 1'b1) begin
			$display("[FAIL] %0t in_ready expected 1 got %b", $time, in_ready);
			tb_errors++;
		end
		#1;
		for (int i = 0; i < row_in.size(); i++) begin
			in       = row_in[i];
			exp_out  = row_exp[i];
			in_valid = 1'b1;
			do begin
				@(posedge clk);
				compare_branch(i);
				accepted = in_ready;
				#1;
			end while (!accepted);
		end
		in_valid = 1'b0;
		while (checked < row_in.size())
			@(negedge clk);
		@(posedge clk);
		#1 report = 1'b1;
		@(posedge clk);
		#1;
		if (tb_errors == 0 && chk_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== ex_stage.f ====
+incdir+hw
hw/ex_op_pkg.sv
hw/ex_pipe_pkg.sv
hw/ex_alu.sv
hw/ex_multiplier.sv
hw/ex_branch_unit.sv
hw/ex_issue_ctrl.sv
hw/ex_stage.sv
tb/ex_stage_checker.sv
tb/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench, result decided from sim.log
verilator --binary --timing -f ex_stage.f --top-module ex_stage_tb -o ex_stage_sim \
	> build.log 2>&1 \
	&& ./obj_dir/ex_stage_sim > sim.log 2>&1 \
	&& ! grep -q "Test failed" sim.log \
	&& echo "simulation ok" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }
